/* include/ls_cfg.svh */
// load-store core configuration: data width, register count, memory depth, reset pc
`ifndef LS_CFG_SVH
`define LS_CFG_SVH

// data path and instruction word width
`define LS_XLEN 16

// architectural registers, r0 reads as zero
`define LS_NREGS 16

// data memory depth in words
`define LS_DMEM_WORDS 64

// first fetch address after reset
`define LS_RESET_PC 0

`endif

/* rtl/ls_pkg.sv */
// load-store core types: opcodes, decoded control and pipeline payloads
`include "ls_cfg.svh"

package ls_pkg;

    localparam int REG_AW = $clog2(`LS_NREGS);

    typedef logic [`LS_XLEN-1:0] word_t;
    typedef logic [REG_AW-1:0]   reg_idx_t;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_ADDI = 4'h3,
        OP_LW   = 4'h4,
        OP_SW   = 4'h5,
        OP_BEQ  = 4'h6,
        OP_JMP  = 4'h7,
        OP_IN   = 4'h8,
        OP_OUT  = 4'h9
    } opcode_t;

    // all zero is a bubble
    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic alu_sub;
        logic alu_imm;
        logic is_branch;
        logic is_jump;
        logic is_in;
        logic is_out;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t ir;
    } if_id_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    pc;
        word_t    a;
        word_t    b;
        word_t    imm;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t src2;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu;
        word_t    store_data;
        reg_idx_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic     reg_write;
        reg_idx_t rd;
        word_t    result;
    } mem_wb_t;

endpackage

/* rtl/fwd_if.sv */
// bypass bundle from the memory and writeback stages back to execute
`timescale 1ns/1ps
`include "ls_cfg.svh"

interface fwd_if;

    // ex/mem stage result
    logic [$clog2(`LS_NREGS)-1:0] mem_rd;
    logic                         mem_we;
    logic [`LS_XLEN-1:0]          mem_val;

    // writeback result
    logic [$clog2(`LS_NREGS)-1:0] wb_rd;
    logic                         wb_we;
    logic [`LS_XLEN-1:0]          wb_val;

    modport src (output mem_rd, mem_we, mem_val, wb_rd, wb_we, wb_val);
    modport sink (input mem_rd, mem_we, mem_val, wb_rd, wb_we, wb_val);

endinterface

/* rtl/stage_reg.sv */
// pipeline register with hold and flush to bubble, generic over its payload
`timescale 1ns/1ps

module stage_reg
    import ls_pkg::*;
#(
    parameter type payload_t = if_id_t
) (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // flush beats hold so a redirect can drop a stalled slot
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

/* rtl/fetch_stage.sv */
// fetch: program counter, instruction rom and next pc select
`timescale 1ns/1ps
`include "ls_cfg.svh"

module fetch_stage
    import ls_pkg::*;
(
    input  logic   clock,
    input  logic   rst_n,
    input  logic   stall,
    input  logic   redirect,
    input  word_t  target,
    output if_id_t fetch_out
);

    word_t pc;
    word_t rom_word;

    // ir layout is {rs2/imm, rs1, rd, op}
    function automatic word_t enc(opcode_t op, logic [3:0] rd, logic [3:0] rs1,
                                  logic [3:0] f);
        return {f, rs1, rd, op};
    endfunction

    always_comb begin
        case (pc)
            16'd0:   rom_word = enc(OP_ADDI, 4'd6, 4'd0, 4'd0);
            16'd1:   rom_word = enc(OP_IN,   4'd1, 4'd0, 4'd0);
            16'd2:   rom_word = enc(OP_BEQ,  4'd0, 4'd1, 4'd1);
            16'd3:   rom_word = enc(OP_ADDI, 4'd6, 4'd0, 4'd1);
            16'd4:   rom_word = enc(OP_ADD,  4'd2, 4'd1, 4'd1);
            16'd5:   rom_word = enc(OP_ADD,  4'd3, 4'd2, 4'd1);
            16'd6:   rom_word = enc(OP_ADDI, 4'd3, 4'd3, 4'hd);
            16'd7:   rom_word = enc(OP_SW,   4'd3, 4'd0, 4'd4);
            16'd8:   rom_word = enc(OP_LW,   4'd4, 4'd0, 4'd4);
            16'd9:   rom_word = enc(OP_ADD,  4'd5, 4'd4, 4'd6);
            16'd10:  rom_word = enc(OP_OUT,  4'd0, 4'd5, 4'd0);
            16'd11:  rom_word = enc(OP_JMP,  4'd0, 4'd0, 4'd0);
            // shadow of the jump, never retired
            16'd12:  rom_word = enc(OP_OUT,  4'd0, 4'd1, 4'd0);
            16'd13:  rom_word = enc(OP_OUT,  4'd0, 4'd0, 4'd0);
            default: rom_word = enc(OP_NOP,  4'd0, 4'd0, 4'd0);
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= word_t'(`LS_RESET_PC);
        end else if (redirect) begin
            pc <= target;
        end else if (!stall) begin
            pc <= pc + word_t'(1);
        end
    end

    assign fetch_out = '{pc: pc, ir: rom_word};

endmodule

/* rtl/decode_stage.sv */
// decode stage that decodes control, reads the register file and detects load-use stalls
`timescale 1ns/1ps
`include "ls_cfg.svh"

module decode_stage
    import ls_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  if_id_t   in_id,
    input  logic     ex_load,
    input  reg_idx_t ex_rd,
    input  mem_wb_t  wb,
    output id_ex_t   out_ex,
    output logic     stall
);

    word_t    regs [`LS_NREGS];
    opcode_t  op;
    ctrl_t    ctrl;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t src2;
    word_t    imm;
    logic     use_rs1;
    logic     use_src2;

    assign op  = opcode_t'(in_id.ir[3:0]);
    assign rd  = in_id.ir[7:4];
    assign rs1 = in_id.ir[11:8];

    // store and branch take their second operand from the rd field
    assign src2 = (op == OP_SW || op == OP_BEQ) ? in_id.ir[7:4] : in_id.ir[15:12];

    always_comb begin
        ctrl     = '0;
        use_rs1  = 1'b0;
        use_src2 = 1'b0;
        case (op)
            OP_ADD:  begin
                ctrl.reg_write = 1'b1;
                use_rs1        = 1'b1;
                use_src2       = 1'b1;
            end
            OP_SUB:  begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_sub   = 1'b1;
                use_rs1        = 1'b1;
                use_src2       = 1'b1;
            end
            OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_imm   = 1'b1;
                use_rs1        = 1'b1;
            end
            OP_LW:   begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.alu_imm   = 1'b1;
                use_rs1        = 1'b1;
            end
            OP_SW:   begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_imm   = 1'b1;
                use_rs1        = 1'b1;
                use_src2       = 1'b1;
            end
            OP_BEQ:  begin
                ctrl.is_branch = 1'b1;
                use_rs1        = 1'b1;
                use_src2       = 1'b1;
            end
            OP_JMP:  ctrl.is_jump = 1'b1;
            OP_IN:   begin
                ctrl.reg_write = 1'b1;
                ctrl.is_in     = 1'b1;
            end
            OP_OUT:  begin
                ctrl.is_out = 1'b1;
                use_rs1     = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // jump carries a 12-bit absolute target and the rest a signed 4-bit field
    assign imm = (op == OP_JMP) ? word_t'(in_id.ir[15:4])
                                : {{(`LS_XLEN-4){in_id.ir[15]}}, in_id.ir[15:12]};

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `LS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // same-cycle writeback is returned to the read
    function automatic word_t read_reg(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wb.reg_write && wb.rd == idx) begin
            return wb.result;
        end
        return regs[idx];
    endfunction

    // lw or in one slot ahead has no value yet
    assign stall = ex_load && ex_rd != '0 &&
                   ((use_rs1 && rs1 == ex_rd) || (use_src2 && src2 == ex_rd));

    always_comb begin
        out_ex = '{ctrl: ctrl, pc: in_id.pc, a: read_reg(rs1), b: read_reg(src2),
                   imm: imm, rd: rd, rs1: rs1, src2: src2};
    end

endmodule

/* rtl/execute_stage.sv */
// execute: operand bypass, alu, branch compare and pc redirect
`timescale 1ns/1ps

module execute_stage
    import ls_pkg::*;
(
    input  id_ex_t      in_ex,
    fwd_if.sink         fwd,
    output ex_mem_t     out_mem,
    output logic        redirect,
    output word_t       target
);

    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t sum;
    word_t alu_out;

    // nearest producer wins, r0 is never bypassed
    always_comb begin
        if (fwd.mem_we && fwd.mem_rd != '0 && fwd.mem_rd == in_ex.rs1) begin
            op_a = fwd.mem_val;
        end else if (fwd.wb_we && fwd.wb_rd != '0 && fwd.wb_rd == in_ex.rs1) begin
            op_a = fwd.wb_val;
        end else begin
            op_a = in_ex.a;
        end
    end

    always_comb begin
        if (fwd.mem_we && fwd.mem_rd != '0 && fwd.mem_rd == in_ex.src2) begin
            op_b = fwd.mem_val;
        end else if (fwd.wb_we && fwd.wb_rd != '0 && fwd.wb_rd == in_ex.src2) begin
            op_b = fwd.wb_val;
        end else begin
            op_b = in_ex.b;
        end
    end

    assign alu_b = in_ex.ctrl.alu_imm ? in_ex.imm : op_b;
    assign sum   = in_ex.ctrl.alu_sub ? op_a - alu_b : op_a + alu_b;

    // out sends rs1 through untouched
    assign alu_out = in_ex.ctrl.is_out ? op_a : sum;

    assign redirect = in_ex.ctrl.is_jump || (in_ex.ctrl.is_branch && op_a == op_b);
    assign target   = in_ex.ctrl.is_jump ? in_ex.imm
                                         : in_ex.pc + word_t'(1) + in_ex.imm;

    assign out_mem = '{ctrl: in_ex.ctrl, alu: alu_out, store_data: op_b, rd: in_ex.rd};

endmodule

/* rtl/mem_stage.sv */
// memory stage: data memory, input port sampling and output port register
`timescale 1ns/1ps
`include "ls_cfg.svh"

module mem_stage
    import ls_pkg::*;
(
    input  logic    clock,
    input  logic    rst_n,
    input  ex_mem_t in_mem,
    input  word_t   read_in,
    output mem_wb_t out_wb,
    output word_t   write_out,
    output logic    out_valid
);

    localparam int DMEM_AW = $clog2(`LS_DMEM_WORDS);

    word_t dmem [`LS_DMEM_WORDS];
    word_t rdata;
    word_t result;

    // word addressed, upper address bits ignored
    assign rdata = dmem[in_mem.alu[DMEM_AW-1:0]];

    always_ff @(posedge clock) begin
        if (in_mem.ctrl.mem_write) begin
            dmem[in_mem.alu[DMEM_AW-1:0]] <= in_mem.store_data;
        end
    end

    always_comb begin
        if (in_mem.ctrl.is_in) begin
            result = read_in;
        end else if (in_mem.ctrl.mem_read) begin
            result = rdata;
        end else begin
            result = in_mem.alu;
        end
    end

    assign out_wb = '{reg_write: in_mem.ctrl.reg_write, rd: in_mem.rd, result: result};

    // one-cycle strobe, write_out keeps the last value
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            write_out <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_mem.ctrl.is_out;
            if (in_mem.ctrl.is_out) begin
                write_out <= in_mem.alu;
            end
        end
    end

endmodule

/* rtl/load_store.sv */
// load_store: five-stage 16-bit core with input and output ports
`timescale 1ns/1ps

module load_store
    import ls_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  word_t read_in,
    output word_t write_out,
    output logic  out_valid
);

    if_id_t  if_id_d;
    if_id_t  if_id_q;
    id_ex_t  id_ex_d;
    id_ex_t  id_ex_q;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;
    mem_wb_t wb;
    logic    stall;
    logic    redirect;
    word_t   target;

    fwd_if fwd ();

    fetch_stage u_fetch (
        .clock     (clock),
        .rst_n     (rst_n),
        .stall     (stall),
        .redirect  (redirect),
        .target    (target),
        .fetch_out (if_id_d)
    );

    stage_reg #(.payload_t(if_id_t)) u_if_id (
        .clock (clock),
        .rst_n (rst_n),
        .hold  (stall),
        .flush (redirect),
        .d     (if_id_d),
        .q     (if_id_q)
    );

    // in also counts as a load, its value arrives in the memory stage
    decode_stage u_decode (
        .clock   (clock),
        .rst_n   (rst_n),
        .in_id   (if_id_q),
        .ex_load (id_ex_q.ctrl.mem_read | id_ex_q.ctrl.is_in),
        .ex_rd   (id_ex_q.rd),
        .wb      (wb),
        .out_ex  (id_ex_d),
        .stall   (stall)
    );

    // a stall leaves a bubble behind the held instruction
    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clock (clock),
        .rst_n (rst_n),
        .hold  (1'b0),
        .flush (stall | redirect),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    execute_stage u_execute (
        .in_ex    (id_ex_q),
        .fwd      (fwd),
        .out_mem  (ex_mem_d),
        .redirect (redirect),
        .target   (target)
    );

    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clock (clock),
        .rst_n (rst_n),
        .hold  (1'b0),
        .flush (1'b0),
        .d     (ex_mem_d),
        .q     (ex_mem_q)
    );

    mem_stage u_mem (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_mem    (ex_mem_q),
        .read_in   (read_in),
        .out_wb    (mem_wb_d),
        .write_out (write_out),
        .out_valid (out_valid)
    );

    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clock (clock),
        .rst_n (rst_n),
        .hold  (1'b0),
        .flush (1'b0),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

    // writeback, writes to r0 are dropped here
    assign wb = '{reg_write: mem_wb_q.reg_write && mem_wb_q.rd != '0,
                  rd: mem_wb_q.rd, result: mem_wb_q.result};

    assign fwd.mem_rd  = ex_mem_q.rd;
    assign fwd.mem_we  = ex_mem_q.ctrl.reg_write;
    assign fwd.mem_val = ex_mem_q.alu;
    assign fwd.wb_rd   = wb.rd;
    assign fwd.wb_we   = wb.reg_write;
    assign fwd.wb_val  = wb.result;

endmodule

/* bench/ls_sva.sv */
// ls_sva: bound checks on the output strobe and the redirect flush of load_store
`timescale 1ns/1ps

module ls_sva
    import ls_pkg::*;
(
    input logic   clock,
    input logic   rst_n,
    input logic   out_valid,
    input logic   redirect,
    input id_ex_t id_ex
);

    int failures = 0;

    // port stays quiet through reset
    reset_quiet: assert property (@(posedge clock) !rst_n |-> !out_valid)
        else begin
            $error("out_valid high while rst_n is low");
            failures++;
        end

    // and in the first cycle after release
    release_quiet: assert property (@(posedge clock) $rose(rst_n) |=> !out_valid)
        else begin
            $error("out_valid high in the first cycle after reset");
            failures++;
        end

    strobe_width: assert property (@(posedge clock) disable iff (!rst_n)
            out_valid |=> !out_valid)
        else begin
            $error("out_valid held high for two cycles");
            failures++;
        end

    // a taken branch or jump leaves a bubble in id/ex
    redirect_flush: assert property (@(posedge clock) disable iff (!rst_n)
            redirect |=> id_ex.ctrl == '0)
        else begin
            $error("id/ex payload carries control flags after a redirect");
            failures++;
        end

endmodule

bind load_store ls_sva sva_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .redirect  (redirect),
    .id_ex     (id_ex_q)
);

/* bench/ls_checker.sv */
// ls_checker: watches the output port of load_store and compares each strobe
`timescale 1ns/1ps

module ls_checker
    import ls_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  logic  out_valid,
    input  word_t write_out,
    input  word_t stimulus,
    input  int    entry,
    input  word_t expected,
    output int    done_count,
    output int    pass_count,
    output int    error_count
);

    int    cur_entry;
    word_t cur_stimulus;
    word_t cur_expected;
    int    last_strobe_entry = -1;
    logic  strobe_seen = 1'b0;
    int    done_n = 0;
    int    pass_n = 0;
    int    error_n = 0;

    assign done_count  = done_n;
    assign pass_count  = pass_n;
    assign error_count = error_n;

    // test inputs move on the falling edge, so latch them on the rising one
    always @(posedge clock) begin
        cur_entry    <= entry;
        cur_stimulus <= stimulus;
        cur_expected <= expected;
    end

    // dut outputs settle after the rising edge
    always @(negedge clock) begin
        if (!rst_n) begin
            if (out_valid !== 1'b0) begin
                $display("out_valid is not low during reset");
                error_n++;
            end
            if (write_out !== '0) begin
                $display("Mismatch write_out in reset: expected 16'h0000 got 16'h%h", write_out);
                error_n++;
            end
        end else if (out_valid !== 1'b0) begin
            if (cur_entry == last_strobe_entry) begin
                $display("test %0d: more than one out_valid strobe, a flushed OUT reached the port",
                         cur_entry);
                error_n++;
            end else begin
                last_strobe_entry = cur_entry;
                strobe_seen       = 1'b1;
                done_n++;
                if (out_valid === 1'b1 && write_out === cur_expected) begin
                    $display("test %0d: read_in 16'h%h write_out 16'h%h ok",
                             cur_entry, cur_stimulus, write_out);
                    pass_n++;
                end else begin
                    $display("Mismatch write_out test %0d: expected 16'h%h got 16'h%h",
                             cur_entry, cur_expected, write_out);
                    error_n++;
                end
            end
        end else if (!strobe_seen && write_out !== '0) begin
            $display("Mismatch write_out before first OUT: expected 16'h0000 got 16'h%h",
                     write_out);
            error_n++;
        end
    end

endmodule

/* bench/load_store_tb.sv */
// load_store testbench: clock, reset, stimulus table, checker and final report
`timescale 1ns/1ps

module load_store_tb
    import ls_pkg::*;
();

    localparam int NUM_TESTS      = 12;
    localparam int RESET_CYCLES   = 16;
    localparam int TAIL_CYCLES    = 8;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 40 * NUM_TESTS + 100;

    logic   clock;
    logic   rst_n;
    word_t  read_in;
    word_t  write_out;
    logic   out_valid;

    word_t  stim_in  [NUM_TESTS];
    word_t  stim_exp [NUM_TESTS];
    int     cur_entry;
    word_t  cur_expected;
    int     done_count;
    int     pass_count;
    int     error_count;
    int     cycles;
    integer seed;

    load_store dut_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .read_in   (read_in),
        .write_out (write_out),
        .out_valid (out_valid)
    );

    ls_checker chk_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .out_valid   (out_valid),
        .write_out   (write_out),
        .stimulus    (read_in),
        .entry       (cur_entry),
        .expected    (cur_expected),
        .done_count  (done_count),
        .pass_count  (pass_count),
        .error_count (error_count)
    );

    // the rom program computes 3x - 3, plus one when x is nonzero
    function automatic word_t expected_result(word_t x);
        word_t r;
        r = x * 16'd3 - 16'd3;
        if (x != '0) begin
            r = r + 16'd1;
        end
        return r;
    endfunction

    task automatic build_table();
        logic [31:0] rnd;
        stim_in[0] = 16'h0000;
        stim_in[1] = 16'h0001;
        stim_in[2] = 16'h7fff;
        stim_in[3] = 16'hffff;
        stim_in[4] = 16'h5555;
        // zero again, after a nonzero pass has set r6
        stim_in[5] = 16'h0000;
        for (int k = 6; k < NUM_TESTS; k++) begin
            rnd        = $random(seed);
            stim_in[k] = rnd[15:0];
        end
        for (int k = 0; k < NUM_TESTS; k++) begin
            stim_exp[k] = expected_result(stim_in[k]);
        end
    endtask

    // checker counts move on the falling edge
    task automatic wait_for_result(int count);
        while (done_count < count) begin
            @(posedge clock);
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: no result after %0d cycles, %0d of %0d tests done",
                 cycles, done_count, NUM_TESTS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int total_errors;
        rst_n        = 1'b0;
        read_in      = '0;
        cur_entry    = 0;
        cur_expected = '0;
        seed         = 32'h0ac3d8ad;
        build_table();

        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        // one table entry per pass through the program
        for (int i = 0; i < NUM_TESTS; i++) begin
            @(negedge clock);
            read_in      = stim_in[i];
            cur_entry    = i;
            cur_expected = stim_exp[i];
            wait_for_result(i + 1);
        end

        // flushed outs would surface within a few cycles
        repeat (TAIL_CYCLES) @(negedge clock);

        total_errors = error_count + dut_i.sva_i.failures;
        $display("summary: %0d tests, %0d results, %0d ok, %0d errors",
                 NUM_TESTS, done_count, pass_count, total_errors);
        if (total_errors == 0 && done_count == NUM_TESTS) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
rtl/ls_pkg.sv
rtl/fwd_if.sv
rtl/stage_reg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/load_store.sv
bench/ls_sva.sv
bench/ls_checker.sv
bench/load_store_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the load_store testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module load_store_tb -f flist.f \
    && ./obj_dir/Vload_store_tb | tee /dev/stderr | grep "Simulation PASSED" > /dev/null \
    && echo "run.sh: ok" \
    || { echo "run.sh: build or simulation failed"; exit 1; }
